// File: sim.f
logic/stream_pkg.sv
logic/line_fifo.sv
logic/page_fill.sv
logic/page_ram.sv
logic/cl_stream_out.sv
logic/page_fetch_ctrl.sv
logic/stream_read_top.sv
dv/stream_read_tb.sv

// File: run.sh
#!/bin/sh
# build and run the page streamer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module stream_read_tb -f sim.f -o stream_read_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/stream_read_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  exit 1
fi
exit 0

// File: dv/stream_read_tb.sv
//////////////////////////////////////////////////
// testbench for the page-buffered read streamer
//////////////////////////////////////////////////
module stream_read_tb;

  localparam int unsigned WAIT_LIMIT = 4000;
  localparam int unsigned PAGE_WORDS = 64;

  logic                 clk;
  logic                 rst_n;
  stream_pkg::rd_req_t  req;
  logic                 req_val;
  logic                 req_rdy;
  stream_pkg::ar_req_t  ar;
  logic                 ar_valid;
  logic                 ar_ready;
  stream_pkg::r_beat_t  r_beat;
  logic                 r_valid;
  logic                 r_ready;
  stream_pkg::cl_beat_t cl;
  logic                 cl_valid;
  logic                 cl_ready;
  logic                 busy;

  bit                   rand_bp;
  bit                   timed_out;
  int unsigned          errors;
  int unsigned          ar_count;
  int unsigned          ar_expected;
  int unsigned          words_seen;
  int unsigned          words_expected;
  int unsigned          last_seen;
  int unsigned          req_total;
  stream_pkg::ar_req_t  last_ar;
  stream_pkg::rd_req_t  exp_q[$];
  bit                   model_tag_valid;
  logic [23:0]          model_tag;
  logic [31:0]          pages [3];

  stream_read_top uut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r_beat),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .cl       (cl),
    .cl_valid (cl_valid),
    .cl_ready (cl_ready),
    .busy     (busy)
  );

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // small fixed hash of the byte address
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] h;
    h = a ^ 32'h5bd1_e995;
    h = h * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return h;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr, input int unsigned i);
    return mem_word({addr[31:2], 2'b00} + (i << 2));
  endfunction

  // memory side line layout, word 0 in the low bits
  function automatic stream_pkg::line_t line_data(input logic [31:0] base,
                                                  input int unsigned beat);
    stream_pkg::line_t line;
    for (int j = 0; j < stream_pkg::WORDS_PER_LINE; j++) begin
      line[j*stream_pkg::WORD_W +: stream_pkg::WORD_W] = mem_word(base + (beat << 4) + 32'(j * 4));
    end
    return line;
  endfunction

  task automatic note_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("error at time %0t: %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  //////////////////////////////////////////////////
  // clock, client ready and memory model
  //////////////////////////////////////////////////
  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin : ready_driver
    cl_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      cl_ready = rand_bp ? (($urandom % 3) != 0) : 1'b1;
    end
  end

  initial begin : memory_model
    bit          burst_on;
    logic [31:0] burst_addr;
    int unsigned beat_idx;
    ar_ready   = 1'b0;
    r_valid    = 1'b0;
    r_beat     = '0;
    burst_on   = 1'b0;
    burst_addr = '0;
    beat_idx   = 0;
    forever begin
      // handshakes are stable half a cycle before the edge
      @(negedge clk);
      if (ar_valid && ar_ready) begin
        ar_count++;
        last_ar    = ar;
        burst_on   = 1'b1;
        burst_addr = ar.addr;
        beat_idx   = 0;
      end
      if (r_valid && r_ready) begin
        beat_idx++;
        if (beat_idx == stream_pkg::LINES_PER_PAGE) begin
          burst_on = 1'b0;
        end
      end
      @(posedge clk);
      #2;
      ar_ready = (($urandom % 2) == 0);
      r_valid  = 1'b0;
      if (burst_on) begin
        r_valid     = (($urandom % 4) != 0);
        r_beat.data = line_data(burst_addr, beat_idx);
        r_beat.last = (beat_idx == stream_pkg::LINES_PER_PAGE - 1);
      end
    end
  end

  //////////////////////////////////////////////////
  // output checker
  //////////////////////////////////////////////////
  initial begin : stream_checker
    stream_pkg::rd_req_t cur;
    bit                  have;
    bit                  held;
    logic [31:0]         held_data;
    logic                held_last;
    int unsigned         idx;
    logic [31:0]         exp_data;
    logic                exp_last;
    have = 1'b0;
    held = 1'b0;
    idx  = 0;
    forever begin
      @(negedge clk);
      // a stalled word must not change
      if (cl_valid) begin
        if (held && (cl.data !== held_data)) begin
          note_mismatch("cl.data held", held_data, cl.data);
        end
        if (held && (cl.last !== held_last)) begin
          note_mismatch("cl.last held", 32'(held_last), 32'(cl.last));
        end
        held      = !cl_ready;
        held_data = cl.data;
        held_last = cl.last;
      end
      if (cl_valid && cl_ready) begin
        if (!have && exp_q.size() > 0) begin
          cur  = exp_q.pop_front();
          have = 1'b1;
          idx  = 0;
        end
        if (!have) begin
          $display("error at time %0t: word taken on cl with no request pending", $time);
          errors++;
        end else begin
          exp_data = expected_word(cur.addr, idx);
          exp_last = cur.last && (idx == 32'(cur.count) - 1);
          if (cl.data !== exp_data) begin
            note_mismatch("cl.data", exp_data, cl.data);
          end
          if (cl.last !== exp_last) begin
            note_mismatch("cl.last", 32'(exp_last), 32'(cl.last));
          end
          if (cl.last) begin
            last_seen++;
          end
          words_seen++;
          idx++;
          if (idx == 32'(cur.count)) begin
            have = 1'b0;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  task automatic wait_req_rdy(output bit ok);
    int unsigned t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!req_rdy && t < WAIT_LIMIT);
    ok = req_rdy;
  endtask

  task automatic run_request(input logic [31:0] addr, input int unsigned count,
                             input bit flush, input bit last);
    stream_pkg::rd_req_t rq;
    bit                  ok;
    bit                  miss;
    rq.addr  = addr;
    rq.count = stream_pkg::COUNT_W'(count);
    rq.flush = flush;
    rq.last  = last;
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    #2;
    req     = rq;
    req_val = 1'b1;
    wait_req_rdy(ok);
    if (!ok) begin
      $display("error at time %0t: request to %h was never accepted", $time, addr);
      errors++;
      timed_out = 1'b1;
      req_val   = 1'b0;
      return;
    end
    // memory is read on a flush or a page change
    miss            = !model_tag_valid || flush || (model_tag != addr[31:8]);
    model_tag_valid = 1'b1;
    model_tag       = addr[31:8];
    if (miss) begin
      ar_expected++;
    end
    exp_q.push_back(rq);
    words_expected += count;
    req_total++;
    @(posedge clk);
    #2;
    req_val = 1'b0;
    wait_req_rdy(ok);
    if (!ok) begin
      $display("error at time %0t: request to %h never finished", $time, addr);
      errors++;
      timed_out = 1'b1;
      return;
    end
    if (words_seen != words_expected) begin
      note_mismatch("word count", words_expected, words_seen);
    end
    if (ar_count != ar_expected) begin
      note_mismatch("ar count", ar_expected, ar_count);
    end
  endtask

  initial begin : main
    int unsigned err0;
    int unsigned last0;
    int unsigned p;
    int unsigned w;
    int unsigned cnt;
    logic [31:0] addr;
    void'($urandom(51));
    pages[0] = 32'h0000_1000;
    pages[1] = 32'h0004_2300;
    pages[2] = 32'h8000_ff00;
    errors   = 0;
    rst_n    = 1'b0;
    req      = '0;
    req_val  = 1'b0;
    rand_bp  = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);

    err0 = errors;
    if (req_rdy !== 1'b1) note_mismatch("req_rdy", 32'd1, 32'(req_rdy));
    if (busy !== 1'b0) note_mismatch("busy", 32'd0, 32'(busy));
    if (ar_valid !== 1'b0) note_mismatch("ar_valid", 32'd0, 32'(ar_valid));
    if (r_ready !== 1'b0) note_mismatch("r_ready", 32'd0, 32'(r_ready));
    if (cl_valid !== 1'b0) note_mismatch("cl_valid", 32'd0, 32'(cl_valid));
    report_test("reset state", err0);

    // first touch of page 0
    err0 = errors;
    run_request(pages[0] + 32'h24, 10, 1'b0, 1'b1);
    if (last_ar.addr !== pages[0]) note_mismatch("ar.addr", pages[0], last_ar.addr);
    if (last_ar.len !== 8'd15) note_mismatch("ar.len", 32'd15, 32'(last_ar.len));
    report_test("miss", err0);

    err0 = errors;
    run_request(pages[0] + 32'h90, 20, 1'b0, 1'b0);
    report_test("hit", err0);

    err0 = errors;
    run_request(pages[0] + 32'h10, 8, 1'b1, 1'b1);
    run_request(pages[1] + 32'h40, 30, 1'b0, 1'b0);
    if (last_ar.addr !== pages[1]) note_mismatch("ar.addr", pages[1], last_ar.addr);
    report_test("flush and new page", err0);

    err0  = errors;
    last0 = last_seen;
    run_request(pages[1] + 32'hc8, 1, 1'b0, 1'b1);
    if (last_seen != last0 + 1) note_mismatch("last count", last0 + 1, last_seen);
    run_request(pages[1] + 32'h04, 5, 1'b0, 1'b0);
    if (last_seen != last0 + 1) note_mismatch("last count", last0 + 1, last_seen);
    report_test("last flag", err0);

    err0    = errors;
    rand_bp = 1'b1;
    for (int n = 0; n < 20; n++) begin
      p    = $urandom % 3;
      w    = $urandom % PAGE_WORDS;
      cnt  = 1 + ($urandom % (PAGE_WORDS - w));
      addr = pages[p] + (w << 2) + ($urandom % 4);
      run_request(addr, cnt, (($urandom % 4) == 0), (($urandom % 2) == 1));
    end
    report_test("back-pressure", err0);

    $display("summary: %0d requests, %0d words, %0d ar requests, %0d last flags, %0d errors",
             req_total, words_seen, ar_count, last_seen, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: logic/stream_read_top.sv
//////////////////////////////////////////////////
// page-buffered read streamer, top level
// controller, line fifo, fill engine, buffer, output
//////////////////////////////////////////////////
module stream_read_top #(
  parameter int FIFO_DEPTH = stream_pkg::LINES_PER_PAGE
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  stream_pkg::rd_req_t  req,
  input  logic                 req_val,
  output logic                 req_rdy,
  output stream_pkg::ar_req_t  ar,
  output logic                 ar_valid,
  input  logic                 ar_ready,
  input  stream_pkg::r_beat_t  r,
  input  logic                 r_valid,
  output logic                 r_ready,
  output stream_pkg::cl_beat_t cl,
  output logic                 cl_valid,
  input  logic                 cl_ready,
  output logic                 busy
);

  logic                                fifo_full;
  logic                                fifo_push;
  logic                                fifo_pop;
  logic                                fifo_empty;
  stream_pkg::line_t                   fifo_line;
  logic                                fill_start;
  logic                                fill_busy;
  logic [stream_pkg::LINE_IDX_W-1:0]   wr_index;
  logic                                wr_en;
  logic [stream_pkg::LINE_IDX_W-1:0]   wr_addr;
  stream_pkg::line_t                   wr_line;
  logic [stream_pkg::LINE_IDX_W-1:0]   rd_index;
  stream_pkg::line_t                   rd_line;
  stream_pkg::rd_req_t                 stream_req;
  logic                                stream_start;
  logic                                stream_done;

  page_fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .ar           (ar),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .r_valid      (r_valid),
    .r_last       (r.last),
    .r_ready      (r_ready),
    .fifo_full    (fifo_full),
    .fifo_push    (fifo_push),
    .fill_busy    (fill_busy),
    .fill_start   (fill_start),
    .stream_req   (stream_req),
    .stream_start (stream_start),
    .stream_done  (stream_done),
    .busy         (busy)
  );

  line_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (fifo_push),
    .din   (r.data),
    .full  (fifo_full),
    .pop   (fifo_pop),
    .dout  (fifo_line),
    .empty (fifo_empty)
  );

  page_fill u_fill (
    .clk        (clk),
    .rst_n      (rst_n),
    .fill_start (fill_start),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .fifo_line  (fifo_line),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_line    (wr_line),
    .fill_busy  (fill_busy),
    .wr_index   (wr_index)
  );

  page_ram #(.DEPTH(stream_pkg::LINES_PER_PAGE)) u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_line (wr_line),
    .rd_addr (rd_index),
    .rd_line (rd_line)
  );

  cl_stream_out u_out (
    .clk          (clk),
    .rst_n        (rst_n),
    .stream_start (stream_start),
    .stream_req   (stream_req),
    .fill_busy    (fill_busy),
    .wr_index     (wr_index),
    .rd_index     (rd_index),
    .rd_line      (rd_line),
    .cl           (cl),
    .cl_valid     (cl_valid),
    .cl_ready     (cl_ready),
    .stream_done  (stream_done)
  );

endmodule

// File: logic/page_fetch_ctrl.sv
//////////////////////////////////////////////////
// main controller: page tag check, burst request,
// read channel acceptance and busy
//////////////////////////////////////////////////
module page_fetch_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  stream_pkg::rd_req_t req,
  input  logic                req_val,
  output logic                req_rdy,
  output stream_pkg::ar_req_t ar,
  output logic                ar_valid,
  input  logic                ar_ready,
  input  logic                r_valid,
  input  logic                r_last,
  output logic                r_ready,
  input  logic                fifo_full,
  output logic                fifo_push,
  input  logic                fill_busy,
  output logic                fill_start,
  output stream_pkg::rd_req_t stream_req,
  output logic                stream_start,
  input  logic                stream_done,
  output logic                busy
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_FILL,
    ST_ADDR,
    ST_DATA,
    ST_XFER
  } state_t;

  state_t                              state_r;
  state_t                              state_nx;
  logic [stream_pkg::PAGE_TAG_W-1:0]   tag_r;
  logic                                tag_valid_r;
  stream_pkg::rd_req_t                 req_r;
  logic                                req_take;
  logic                                hit;
  logic                                start_hit;

  //////////////////////////////////////////////////
  // tag check and request capture
  //////////////////////////////////////////////////
  assign req_take  = (state_r == ST_IDLE) && req_val;
  assign hit       = tag_valid_r && !req.flush &&
                     (req.addr[stream_pkg::ADDR_W-1 -: stream_pkg::PAGE_TAG_W] == tag_r);
  assign start_hit = req_take && hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_valid_r <= 1'b0;
    end else if (req_take) begin
      tag_valid_r <= 1'b1;
    end
  end

  // a miss loads the new page, a hit rewrites the same tag
  always_ff @(posedge clk) begin
    if (req_take) begin
      tag_r <= req.addr[stream_pkg::ADDR_W-1 -: stream_pkg::PAGE_TAG_W];
      req_r <= req;
    end
  end

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_nx;
    end
  end

  always_comb begin
    state_nx = state_r;
    case (state_r)
      ST_IDLE: begin
        if (req_val) begin
          state_nx = hit ? ST_XFER : ST_WAIT_FILL;
        end
      end
      // previous fill may still be draining the fifo
      ST_WAIT_FILL: if (!fill_busy) state_nx = ST_ADDR;
      ST_ADDR:      if (ar_ready) state_nx = ST_DATA;
      ST_DATA:      if (fifo_push && r_last) state_nx = ST_XFER;
      ST_XFER:      if (stream_done) state_nx = ST_IDLE;
      default:      state_nx = ST_IDLE;
    endcase
  end

  // outputs
  assign req_rdy      = (state_r == ST_IDLE);
  assign fill_start   = (state_r == ST_WAIT_FILL) && !fill_busy;
  // streamer starts with the fill so it can follow the write index
  assign stream_start = start_hit || fill_start;
  assign stream_req   = start_hit ? req : req_r;

  assign ar.addr  = {req_r.addr[stream_pkg::ADDR_W-1 -: stream_pkg::PAGE_TAG_W],
                     {stream_pkg::PAGE_OFFSET_W{1'b0}}};
  assign ar.len   = 8'(stream_pkg::LINES_PER_PAGE - 1);
  assign ar_valid = (state_r == ST_ADDR);

  assign r_ready   = (state_r == ST_DATA) && !fifo_full;
  assign fifo_push = r_valid && r_ready;

  assign busy = (state_r != ST_IDLE) || !stream_done;

endmodule

// File: logic/cl_stream_out.sv
//////////////////////////////////////////////////
// output streamer: buffer read, word select,
// burst countdown and last flag
//////////////////////////////////////////////////
module cl_stream_out (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              stream_start,
  input  stream_pkg::rd_req_t               stream_req,
  input  logic                              fill_busy,
  input  logic [stream_pkg::LINE_IDX_W-1:0] wr_index,
  output logic [stream_pkg::LINE_IDX_W-1:0] rd_index,
  input  stream_pkg::line_t                 rd_line,
  output stream_pkg::cl_beat_t              cl,
  output logic                              cl_valid,
  input  logic                              cl_ready,
  output logic                              stream_done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_XFER,
    ST_LINE_READ
  } state_t;

  state_t                               state_r;
  logic [stream_pkg::LINE_IDX_W-1:0]    line_idx;
  logic [stream_pkg::WORD_SEL_W-1:0]    word_sel;
  logic [stream_pkg::COUNT_W-1:0]       remain;
  logic                                 last_r;
  logic                                 read_ok;
  logic                                 xfer;
  logic                                 final_word;

  // line is readable once the fill has written past it
  assign read_ok    = !fill_busy || (line_idx < wr_index);
  assign final_word = (remain == stream_pkg::COUNT_W'(1));

  assign rd_index    = line_idx;
  assign stream_done = (state_r == ST_IDLE);
  assign cl_valid    = (state_r == ST_XFER) && read_ok;
  assign xfer        = cl_valid && cl_ready;
  assign cl.data     = rd_line[word_sel*stream_pkg::WORD_W +: stream_pkg::WORD_W];
  assign cl.last     = last_r && final_word;

  //////////////////////////////////////////////////
  // counters and state
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_r  <= ST_IDLE;
      line_idx <= '0;
      word_sel <= '0;
      remain   <= '0;
      last_r   <= 1'b0;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (stream_start) begin
            line_idx <= stream_req.addr[stream_pkg::PAGE_OFFSET_W-1 -: stream_pkg::LINE_IDX_W];
            word_sel <= stream_req.addr[stream_pkg::PAGE_OFFSET_W-stream_pkg::LINE_IDX_W-1
                                        -: stream_pkg::WORD_SEL_W];
            remain   <= stream_req.count;
            last_r   <= stream_req.last;
            // an empty request finishes at once
            if (stream_req.count != '0) begin
              state_r <= ST_LINE_READ;
            end
          end
        end
        // ram captures rd_index on the edge leaving this state
        ST_LINE_READ: begin
          if (read_ok) begin
            state_r <= ST_XFER;
          end
        end
        ST_XFER: begin
          if (xfer) begin
            remain   <= remain - 1'b1;
            word_sel <= word_sel + 1'b1;
            if (final_word) begin
              state_r <= ST_IDLE;
            end else if (word_sel ==
                         stream_pkg::WORD_SEL_W'(stream_pkg::WORDS_PER_LINE - 1)) begin
              line_idx <= line_idx + 1'b1;
              state_r  <= ST_LINE_READ;
            end
          end
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: logic/page_ram.sv
//////////////////////////////////////////////////
// page buffer, one write port, registered read
//////////////////////////////////////////////////
module page_ram #(
  parameter int DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  stream_pkg::line_t        wr_line,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output stream_pkg::line_t        rd_line
);

  stream_pkg::line_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_line;
    end
    rd_line <= mem[rd_addr];
  end

endmodule

// File: logic/page_fill.sv
//////////////////////////////////////////////////
// fill engine, fifo lines into the page buffer
//////////////////////////////////////////////////
module page_fill (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              fill_start,
  input  logic                              fifo_empty,
  output logic                              fifo_pop,
  input  stream_pkg::line_t                 fifo_line,
  output logic                              wr_en,
  output logic [stream_pkg::LINE_IDX_W-1:0] wr_addr,
  output stream_pkg::line_t                 wr_line,
  output logic                              fill_busy,
  output logic [stream_pkg::LINE_IDX_W-1:0] wr_index
);

  logic filling_r;

  assign fill_busy = filling_r;
  assign fifo_pop  = filling_r && !fifo_empty;
  assign wr_en     = fifo_pop;
  assign wr_addr   = wr_index;
  assign wr_line   = fifo_line;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      filling_r <= 1'b0;
      wr_index  <= '0;
    end else if (!filling_r) begin
      if (fill_start) begin
        filling_r <= 1'b1;
        wr_index  <= '0;
      end
    end else if (fifo_pop) begin
      // index wraps to zero after the last line
      wr_index <= wr_index + 1'b1;
      if (wr_index == stream_pkg::LINE_IDX_W'(stream_pkg::LINES_PER_PAGE - 1)) begin
        filling_r <= 1'b0;
      end
    end
  end

endmodule

// File: logic/line_fifo.sv
//////////////////////////////////////////////////
// synchronous first-word-fall-through line fifo
//////////////////////////////////////////////////
module line_fifo #(
  parameter int DEPTH = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push,
  input  stream_pkg::line_t din,
  output logic              full,
  input  logic              pop,
  output stream_pkg::line_t dout,
  output logic              empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  stream_pkg::line_t mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              do_push;
  logic              do_pop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  // head entry is visible without a read cycle
  assign dout    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: logic/stream_pkg.sv
//////////////////////////////////////////////////
// page streamer shared sizes and bus types
//////////////////////////////////////////////////
package stream_pkg;

  // address and page geometry
  localparam int ADDR_W         = 32;
  localparam int PAGE_OFFSET_W  = 8;
  localparam int LINE_W         = 128;
  localparam int WORD_W         = 32;

  // derived sizes
  localparam int LINES_PER_PAGE = (1 << PAGE_OFFSET_W) / (LINE_W / 8);
  localparam int LINE_IDX_W     = $clog2(LINES_PER_PAGE);
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
  localparam int PAGE_TAG_W     = ADDR_W - PAGE_OFFSET_W;
  localparam int COUNT_W        = 9;

  typedef logic [LINE_W-1:0] line_t;

  // client request
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic [COUNT_W-1:0] count;
    logic               flush;
    logic               last;
  } rd_req_t;

  // memory read address, len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } ar_req_t;

  typedef struct packed {
    line_t data;
    logic  last;
  } r_beat_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
  } cl_beat_t;

endpackage
